// File: design/cache_pkg.sv
// cache geometry, address views and the cache request and status types, imported by the RTL
package cache_pkg;

    localparam int unsigned ADDR_WIDTH   = 12;
    localparam int unsigned DATA_WIDTH   = 32;
    localparam int unsigned LINE_SIZE    = 16;
    localparam int unsigned CACHE_SIZE   = 256;
    localparam int unsigned INDEX_COUNT  = CACHE_SIZE / LINE_SIZE;
    localparam int unsigned OFFSET_WIDTH = $clog2(LINE_SIZE);
    localparam int unsigned INDEX_WIDTH  = $clog2(INDEX_COUNT);
    localparam int unsigned TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int unsigned LINE_WIDTH   = LINE_SIZE * 8;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } cache_addr_fields_t;

    // one address word, seen either as a flat byte address or split for lookup
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        cache_addr_fields_t    f;
    } cache_addr_u;

    typedef struct packed {
        logic                    rd_en;
        logic                    wr_en;
        logic                    fill_en;
        logic                    fill_valid;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [INDEX_WIDTH-1:0]  index;
        logic [TAG_WIDTH-1:0]    tag;
        logic [LINE_WIDTH-1:0]   fill_line;
        logic [DATA_WIDTH-1:0]   wr_word;
    } cache_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic                  hit;
        logic [TAG_WIDTH-1:0]  victim_tag;
        logic [LINE_WIDTH-1:0] victim_line;
        logic [DATA_WIDTH-1:0] rd_word;
    } cache_stat_t;

endpackage

// File: design/bus_pkg.sv
// AXI4-Lite channel types and backing-memory request and response types for the cache front end
package bus_pkg;

    localparam int unsigned LINE_ADDR_WIDTH = cache_pkg::TAG_WIDTH + cache_pkg::INDEX_WIDTH;
    localparam logic [1:0]  RESP_OKAY       = 2'b00;

    typedef struct packed {
        logic                            valid;
        logic [cache_pkg::ADDR_WIDTH-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic                            valid;
        logic [cache_pkg::ADDR_WIDTH-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic                                valid;
        logic [cache_pkg::DATA_WIDTH-1:0]     data;
        logic [cache_pkg::DATA_WIDTH/8-1:0]   strb;
    } axi_w_t;

    typedef struct packed {
        logic                            valid;
        logic [cache_pkg::DATA_WIDTH-1:0] data;
        logic [1:0]                      resp;
    } axi_r_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

    // line address is the tag and index of a byte address
    typedef struct packed {
        logic                            valid;
        logic                            write;
        logic [LINE_ADDR_WIDTH-1:0]      line_addr;
        logic [cache_pkg::LINE_WIDTH-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic                            ack;
        logic [cache_pkg::LINE_WIDTH-1:0] data;
    } mem_rsp_t;

endpackage

// File: design/dp_ram.sv
// one-read one-write synchronous RAM with registered read data, used for cache tags and lines
`timescale 1ns/1ns

module dp_ram #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned RAM_DEPTH  = 16
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         i_ram_rd_en,
    input  logic [$clog2(RAM_DEPTH)-1:0] i_ram_rd_addr,
    output logic [DATA_WIDTH-1:0]        o_ram_rd_data,
    input  logic                         i_ram_wr_en,
    input  logic [$clog2(RAM_DEPTH)-1:0] i_ram_wr_addr,
    input  logic [DATA_WIDTH-1:0]        i_ram_wr_data
);

    logic [DATA_WIDTH-1:0] mem [0:RAM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (i_ram_wr_en) begin
            mem[i_ram_wr_addr] <= i_ram_wr_data;
        end
    end

    // read data holds its last value while no read is issued
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            o_ram_rd_data <= '0;
        end else if (i_ram_rd_en) begin
            o_ram_rd_data <= mem[i_ram_rd_addr];
        end
    end

endmodule

// File: design/cache.sv
// direct-mapped cache arrays with valid and dirty state, driven one request at a time by cache_ctrl
`timescale 1ns/1ns

module cache (
    input  logic                   clk,
    input  logic                   n_rst,
    input  cache_pkg::cache_req_t  i_req,
    output cache_pkg::cache_stat_t o_stat
);
    import cache_pkg::*;

    localparam int unsigned BYTE_SEL_WIDTH = $clog2(DATA_WIDTH / 8);

    logic [INDEX_COUNT-1:0]                   valid_q;
    logic [INDEX_COUNT-1:0]                   dirty_q;
    logic                                     line_hit;
    logic                                     word_we;
    logic [OFFSET_WIDTH-BYTE_SEL_WIDTH-1:0]   word_sel;

    logic                                     ram_rd_en;
    logic                                     data_wr_en;
    logic [LINE_WIDTH-1:0]                    data_rd_line;
    logic [LINE_WIDTH-1:0]                    data_wr_line;
    logic [TAG_WIDTH-1:0]                     tag_rd;

    // low offset bits pick a byte inside the word and are ignored
    assign word_sel = i_req.offset[OFFSET_WIDTH-1:BYTE_SEL_WIDTH];

    // the tag compare uses the registered RAM output, so status lags the request by a cycle
    assign line_hit = (tag_rd == i_req.tag) && valid_q[i_req.index];

    // a word write lands only on a line that already holds the tag
    assign word_we = i_req.wr_en && line_hit;

    assign ram_rd_en  = i_req.rd_en || i_req.wr_en || i_req.fill_en;
    assign data_wr_en = word_we || i_req.fill_en;

    // merge the new word into the line read out by the previous lookup
    always_comb begin
        data_wr_line = data_rd_line;
        if (i_req.fill_en) begin
            data_wr_line = i_req.fill_line;
        end else begin
            data_wr_line[word_sel*DATA_WIDTH +: DATA_WIDTH] = i_req.wr_word;
        end
    end

    assign o_stat = '{
        valid:       valid_q[i_req.index],
        dirty:       dirty_q[i_req.index],
        hit:         line_hit,
        victim_tag:  tag_rd,
        victim_line: data_rd_line,
        rd_word:     data_rd_line[word_sel*DATA_WIDTH +: DATA_WIDTH]
    };

    // a fill brings in a clean line, a word write marks it dirty
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_req.fill_en) begin
            valid_q[i_req.index] <= i_req.fill_valid;
            dirty_q[i_req.index] <= 1'b0;
        end else if (word_we) begin
            dirty_q[i_req.index] <= 1'b1;
        end
    end

    dp_ram #(
        .DATA_WIDTH(LINE_WIDTH),
        .RAM_DEPTH(INDEX_COUNT)
    ) data_ram (
        .clk(clk),
        .n_rst(n_rst),
        .i_ram_rd_en(ram_rd_en),
        .i_ram_rd_addr(i_req.index),
        .o_ram_rd_data(data_rd_line),
        .i_ram_wr_en(data_wr_en),
        .i_ram_wr_addr(i_req.index),
        .i_ram_wr_data(data_wr_line)
    );

    // tags change only when a whole line is filled
    dp_ram #(
        .DATA_WIDTH(TAG_WIDTH),
        .RAM_DEPTH(INDEX_COUNT)
    ) tag_ram (
        .clk(clk),
        .n_rst(n_rst),
        .i_ram_rd_en(ram_rd_en),
        .i_ram_rd_addr(i_req.index),
        .o_ram_rd_data(tag_rd),
        .i_ram_wr_en(i_req.fill_en),
        .i_ram_wr_addr(i_req.index),
        .i_ram_wr_data(i_req.tag)
    );

endmodule

// File: design/line_mem.sv
// line-wide backing memory behind the cache, answering each request after a fixed latency
`timescale 1ns/1ns

module line_mem #(
    parameter int unsigned MEM_LATENCY = 3
) (
    input  logic              clk,
    input  logic              n_rst,
    input  bus_pkg::mem_req_t i_req,
    output bus_pkg::mem_rsp_t o_rsp
);
    import cache_pkg::*;
    import bus_pkg::*;

    localparam int unsigned LINE_COUNT = 2 ** LINE_ADDR_WIDTH;
    localparam int unsigned CNT_WIDTH  = $clog2(MEM_LATENCY + 1);

    logic [LINE_WIDTH-1:0] mem [0:LINE_COUNT-1];
    logic [CNT_WIDTH-1:0]  cnt_q;
    logic                  ack_q;
    logic [LINE_WIDTH-1:0] rdata_q;
    logic                  done;

    // the request is served on its last counted cycle and ack follows on the next edge
    assign done = i_req.valid && !ack_q && (cnt_q == CNT_WIDTH'(MEM_LATENCY - 1));

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            cnt_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= done;
            if (done) begin
                cnt_q <= '0;
            end else if (i_req.valid && !ack_q) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            if (i_req.write) begin
                mem[i_req.line_addr] <= i_req.data;
            end
            rdata_q <= mem[i_req.line_addr];
        end
    end

    assign o_rsp = '{ack: ack_q, data: rdata_q};

endmodule

// File: design/cache_ctrl.sv
// AXI4-Lite front end of the cache that runs lookups, write-back and fill on a miss
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                   clk,
    input  logic                   n_rst,
    input  bus_pkg::axi_ar_t       i_ar,
    output logic                   o_arready,
    output bus_pkg::axi_r_t        o_r,
    input  logic                   i_rready,
    input  bus_pkg::axi_aw_t       i_aw,
    input  bus_pkg::axi_w_t        i_w,
    output logic                   o_awready,
    output logic                   o_wready,
    output bus_pkg::axi_b_t        o_b,
    input  logic                   i_bready,
    output cache_pkg::cache_req_t  o_creq,
    input  cache_pkg::cache_stat_t i_cstat,
    output bus_pkg::mem_req_t      o_mreq,
    input  bus_pkg::mem_rsp_t      i_mrsp
);
    import cache_pkg::*;
    import bus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_CHECK,
        ST_WRITEBACK,
        ST_FILL,
        ST_UPDATE,
        ST_RESPOND
    } state_e;

    state_e                state_q;
    state_e                state_d;
    cache_addr_u           addr_q;
    cache_addr_u           cur_addr;
    cache_addr_u           victim_addr;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic                  is_write_q;
    logic                  r_valid_q;
    logic [DATA_WIDTH-1:0] r_data_q;
    logic                  b_valid_q;
    logic                  accept_rd;
    logic                  accept_wr;
    logic                  read_hit;

    // reads win when both channels present a request in the same cycle
    assign accept_rd = (state_q == ST_IDLE) && i_ar.valid;
    assign accept_wr = (state_q == ST_IDLE) && i_aw.valid && i_w.valid && !i_ar.valid;
    assign read_hit  = (state_q == ST_CHECK) && i_cstat.hit && !is_write_q;

    assign o_arready = (state_q == ST_IDLE);
    assign o_awready = accept_wr;
    assign o_wready  = accept_wr;

    assign o_r = '{valid: r_valid_q, data: r_data_q, resp: RESP_OKAY};
    assign o_b = '{valid: b_valid_q, resp: RESP_OKAY};

    // the first lookup is issued in the accept cycle straight from the bus
    always_comb begin
        if (state_q == ST_IDLE) begin
            cur_addr.flat = i_ar.valid ? i_ar.addr : i_aw.addr;
        end else begin
            cur_addr = addr_q;
        end
    end

    always_comb begin
        victim_addr.f.tag    = i_cstat.victim_tag;
        victim_addr.f.index  = addr_q.f.index;
        victim_addr.f.offset = '0;
    end

    always_comb begin
        o_creq            = '0;
        o_creq.tag        = cur_addr.f.tag;
        o_creq.index      = cur_addr.f.index;
        o_creq.offset     = cur_addr.f.offset;
        o_creq.wr_word    = wdata_q;
        o_creq.fill_line  = i_mrsp.data;
        o_creq.fill_valid = 1'b1;
        case (state_q)
            ST_IDLE:   o_creq.rd_en   = accept_rd || accept_wr;
            ST_LOOKUP: o_creq.rd_en   = 1'b1;
            // fill data is only valid in the ack cycle
            ST_FILL:   o_creq.fill_en = i_mrsp.ack;
            ST_UPDATE: o_creq.wr_en   = 1'b1;
            default:   o_creq.rd_en   = 1'b0;
        endcase
    end

    always_comb begin
        o_mreq = '0;
        if (state_q == ST_WRITEBACK) begin
            o_mreq.valid     = 1'b1;
            o_mreq.write     = 1'b1;
            o_mreq.line_addr = victim_addr.flat[ADDR_WIDTH-1:OFFSET_WIDTH];
            o_mreq.data      = i_cstat.victim_line;
        end else if (state_q == ST_FILL) begin
            o_mreq.valid     = 1'b1;
            o_mreq.line_addr = addr_q.flat[ADDR_WIDTH-1:OFFSET_WIDTH];
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept_rd || accept_wr) begin
                    state_d = ST_CHECK;
                end
            end
            ST_LOOKUP: state_d = ST_CHECK;
            ST_CHECK: begin
                if (i_cstat.hit) begin
                    state_d = is_write_q ? ST_UPDATE : ST_RESPOND;
                end else if (i_cstat.valid && i_cstat.dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_FILL;
                end
            end
            ST_WRITEBACK: begin
                if (i_mrsp.ack) begin
                    state_d = ST_FILL;
                end
            end
            // after the fill the access is replayed against the new line
            ST_FILL: begin
                if (i_mrsp.ack) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_UPDATE: state_d = ST_RESPOND;
            ST_RESPOND: begin
                if ((r_valid_q && i_rready) || (b_valid_q && i_bready)) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_q    <= ST_IDLE;
            is_write_q <= 1'b0;
            r_valid_q  <= 1'b0;
            b_valid_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept_rd || accept_wr) begin
                is_write_q <= accept_wr;
            end
            if (read_hit) begin
                r_valid_q <= 1'b1;
            end else if (r_valid_q && i_rready) begin
                r_valid_q <= 1'b0;
            end
            if (state_q == ST_UPDATE) begin
                b_valid_q <= 1'b1;
            end else if (b_valid_q && i_bready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_rd || accept_wr) begin
            addr_q  <= cur_addr;
            wdata_q <= i_w.data;
        end
        if (read_hit) begin
            r_data_q <= i_cstat.rd_word;
        end
    end

endmodule

// File: design/cache_top.sv
// top level of the cached memory, an AXI4-Lite slave built from cache_ctrl, cache and line_mem
`timescale 1ns/1ns

module cache_top #(
    parameter int unsigned MEM_LATENCY = 3
) (
    input  logic             clk,
    input  logic             n_rst,
    input  bus_pkg::axi_ar_t i_ar,
    output logic             o_arready,
    output bus_pkg::axi_r_t  o_r,
    input  logic             i_rready,
    input  bus_pkg::axi_aw_t i_aw,
    input  bus_pkg::axi_w_t  i_w,
    output logic             o_awready,
    output logic             o_wready,
    output bus_pkg::axi_b_t  o_b,
    input  logic             i_bready
);
    import cache_pkg::*;
    import bus_pkg::*;

    cache_req_t  creq;
    cache_stat_t cstat;
    mem_req_t    mreq;
    mem_rsp_t    mrsp;

    cache_ctrl u_ctrl (
        .clk(clk),
        .n_rst(n_rst),
        .i_ar(i_ar),
        .o_arready(o_arready),
        .o_r(o_r),
        .i_rready(i_rready),
        .i_aw(i_aw),
        .i_w(i_w),
        .o_awready(o_awready),
        .o_wready(o_wready),
        .o_b(o_b),
        .i_bready(i_bready),
        .o_creq(creq),
        .i_cstat(cstat),
        .o_mreq(mreq),
        .i_mrsp(mrsp)
    );

    cache u_cache (
        .clk(clk),
        .n_rst(n_rst),
        .i_req(creq),
        .o_stat(cstat)
    );

    line_mem #(
        .MEM_LATENCY(MEM_LATENCY)
    ) u_mem (
        .clk(clk),
        .n_rst(n_rst),
        .i_req(mreq),
        .o_rsp(mrsp)
    );

endmodule

// File: test/tb_clock.sv
// testbench clock and reset source for the cache testbench, instantiated once by cache_tb
`timescale 1ns/1ns

module tb_clock #(
    parameter int unsigned HALF_PERIOD  = 10,
    parameter int unsigned RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_n_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // reset is released a little after an edge so it never races the flops
    initial begin
        o_n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #2 o_n_rst = 1'b1;
    end

endmodule

// File: test/cache_assertions.sv
// protocol checks on the AXI4-Lite responses and the line memory request, bound into cache_ctrl
`timescale 1ns/1ns

module cache_assertions (
    input logic              clk,
    input logic              n_rst,
    input bus_pkg::axi_r_t   i_r,
    input logic              i_rready,
    input bus_pkg::axi_b_t   i_b,
    input logic              i_bready,
    input bus_pkg::mem_req_t i_mreq,
    input bus_pkg::mem_rsp_t i_mrsp
);

    // count of failed assertions, watched by the testbench
    int unsigned error_count = 0;

    // read data and valid stay put until the master takes them
    r_hold: assert property (@(posedge clk) disable iff (!n_rst)
        i_r.valid && !i_rready |=> i_r.valid && $stable(i_r.data))
    else begin
        $error("read response changed before i_rready");
        error_count++;
    end

    b_hold: assert property (@(posedge clk) disable iff (!n_rst)
        i_b.valid && !i_bready |=> i_b.valid)
    else begin
        $error("write response dropped before i_bready");
        error_count++;
    end

    // only one transaction is in flight, so only one response can be pending
    one_response: assert property (@(posedge clk) disable iff (!n_rst)
        !(i_r.valid && i_b.valid))
    else begin
        $error("read and write responses valid together");
        error_count++;
    end

    mreq_hold: assert property (@(posedge clk) disable iff (!n_rst)
        i_mreq.valid && !i_mrsp.ack |=> i_mreq.valid)
    else begin
        $error("memory request dropped before ack");
        error_count++;
    end

endmodule

// File: test/cache_tb.sv
// table-driven testbench for cache_top, checks read data against a word model of all writes
`timescale 1ns/1ns

module cache_tb;
    import cache_pkg::*;
    import bus_pkg::*;

    localparam int unsigned WORD_COUNT     = 2 ** (ADDR_WIDTH - 2);
    localparam int unsigned TIMEOUT_CYCLES = 200;
    localparam int unsigned DRIVE_DELAY    = 2;
    localparam int          SEED           = 56797;

    // one table row: the operation, its address and the write data or the expected read data
    typedef struct packed {
        logic                  is_write;
        logic                  backpressure;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } step_t;

    logic     clk;
    logic     n_rst;
    axi_ar_t  ar;
    logic     arready;
    axi_r_t   r;
    logic     rready;
    axi_aw_t  aw;
    axi_w_t   w;
    logic     awready;
    logic     wready;
    axi_b_t   b;
    logic     bready;

    step_t                 steps[$];
    logic [DATA_WIDTH-1:0] model [0:WORD_COUNT-1];
    bit                    written [0:WORD_COUNT-1];
    integer                seed;

    tb_clock u_clock (
        .o_clk(clk),
        .o_n_rst(n_rst)
    );

    cache_top #(
        .MEM_LATENCY(3)
    ) DUT (
        .clk(clk),
        .n_rst(n_rst),
        .i_ar(ar),
        .o_arready(arready),
        .o_r(r),
        .i_rready(rready),
        .i_aw(aw),
        .i_w(w),
        .o_awready(awready),
        .o_wready(wready),
        .o_b(b),
        .i_bready(bready)
    );

    bind cache_ctrl cache_assertions u_assert (
        .clk(clk),
        .n_rst(n_rst),
        .i_r(o_r),
        .i_rready(i_rready),
        .i_b(o_b),
        .i_bready(i_bready),
        .i_mreq(o_mreq),
        .i_mrsp(i_mrsp)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    // a failed protocol assertion ends the run on the next clock edge
    always @(posedge clk) begin
        if (DUT.u_ctrl.u_assert.error_count != 0) begin
            abort_run("protocol assertions reported errors during the run");
        end
    end

    task automatic add_write(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data, input bit bp);
        step_t s;
        s = '{is_write: 1'b1, backpressure: bp, addr: addr, data: data};
        model[addr[ADDR_WIDTH-1:2]]   = data;
        written[addr[ADDR_WIDTH-1:2]] = 1'b1;
        steps.push_back(s);
    endtask

    task automatic add_random_write(input logic [ADDR_WIDTH-1:0] addr, input bit bp);
        logic [DATA_WIDTH-1:0] data;
        data = $random(seed);
        add_write(addr, data, bp);
    endtask

    // the expected value of a read is whatever the model holds at this point of the table
    task automatic add_read(input logic [ADDR_WIDTH-1:0] addr, input bit bp);
        step_t s;
        assert (written[addr[ADDR_WIDTH-1:2]]) else begin
            abort_run($sformatf("table reads address %h before any write to it", addr));
        end
        s = '{is_write: 1'b0, backpressure: bp, addr: addr, data: model[addr[ADDR_WIDTH-1:2]]};
        steps.push_back(s);
    endtask

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input int tag, input int idx,
                                                         input int word);
        return ADDR_WIDTH'((tag << 8) | (idx << 4) | ((word % 4) << 2));
    endfunction

    // holds the response for a random stretch when back-pressure is on, checking it stays put
    task automatic accept_response(input bit is_write, input step_t s);
        int unsigned n;
        int unsigned stall;
        n = 0;
        @(negedge clk);
        while (!(is_write ? b.valid : r.valid)) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run("timeout waiting for a response from the DUT");
            end
            @(negedge clk);
        end
        if (!is_write) begin
            check_value("o_r.data", r.data, s.data);
            check_value("o_r.resp", r.resp, RESP_OKAY);
        end else begin
            check_value("o_b.resp", b.resp, RESP_OKAY);
        end
        if (s.backpressure) begin
            stall = {$random(seed)} % 6;
            for (int j = 0; j <= stall; j++) begin
                @(posedge clk);
                #(DRIVE_DELAY);
                if (j == stall) begin
                    rready = !is_write;
                    bready = is_write;
                end
                @(negedge clk);
                if (is_write) begin
                    check_value("o_b.valid", b.valid, 1'b1);
                end else begin
                    check_value("o_r.valid", r.valid, 1'b1);
                    check_value("o_r.data", r.data, s.data);
                end
            end
        end
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic run_step(input step_t s);
        int unsigned n;
        rready = !s.backpressure;
        bready = !s.backpressure;
        if (s.is_write) begin
            aw = '{valid: 1'b1, addr: s.addr};
            w  = '{valid: 1'b1, data: s.data, strb: '1};
        end else begin
            ar = '{valid: 1'b1, addr: s.addr};
        end
        n = 0;
        @(negedge clk);
        while (s.is_write ? !(awready && wready) : !arready) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run("timeout waiting for the DUT to accept a request");
            end
            @(negedge clk);
        end
        // the write channels stay closed while no write address and data are offered
        if (!s.is_write) begin
            check_value("o_awready", awready, 1'b0);
            check_value("o_wready", wready, 1'b0);
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        ar = '0;
        aw = '0;
        w  = '0;
        accept_response(s.is_write, s);
    endtask

    initial begin
        int unsigned n;
        seed    = SEED;
        ar      = '0;
        aw      = '0;
        w       = '0;
        rready  = 1'b0;
        bready  = 1'b0;
        for (int i = 0; i < WORD_COUNT; i++) begin
            written[i] = 1'b0;
        end

        // a word and then the rest of its line
        add_write(12'h048, 32'hcafe_0048, 1'b0);
        add_read(12'h048, 1'b0);
        add_write(12'h040, 32'h1111_0040, 1'b0);
        add_write(12'h044, 32'h2222_0044, 1'b0);
        add_write(12'h04c, 32'h3333_004c, 1'b0);
        add_read(12'h040, 1'b0);
        add_read(12'h044, 1'b0);
        add_read(12'h04c, 1'b0);
        // same index, two tags, so the first line is evicted dirty and refilled
        add_write(12'h150, 32'ha5a5_0150, 1'b0);
        add_write(12'h250, 32'h5a5a_0250, 1'b0);
        add_read(12'h150, 1'b0);
        add_read(12'h250, 1'b0);
        // every index under several tags, then overwrites of some of them
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 16; i++) begin
                add_random_write(make_addr(t, i, t + i), 1'b0);
            end
        end
        for (int t = 3; t >= 0; t--) begin
            for (int i = 0; i < 16; i++) begin
                add_read(make_addr(t, i, t + i), 1'b0);
            end
        end
        for (int t = 0; t < 2; t++) begin
            for (int i = 15; i >= 0; i--) begin
                add_random_write(make_addr(t, i, t + i), 1'b0);
            end
        end
        for (int i = 0; i < 16; i++) begin
            for (int t = 0; t < 4; t++) begin
                add_read(make_addr(t, i, t + i), 1'b0);
            end
        end
        // the same kind of traffic with the master stalling the responses
        for (int i = 0; i < 16; i++) begin
            add_random_write(make_addr(6, i, i), 1'b1);
            add_read(make_addr(6, i, i), 1'b1);
            add_read(make_addr(i % 4, i, i + i % 4), 1'b1);
        end

        n = 0;
        @(negedge clk);
        while (n_rst !== 1'b1) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run("timeout waiting for reset release");
            end
            @(negedge clk);
        end
        check_value("o_r.valid", r.valid, 1'b0);
        check_value("o_b.valid", b.valid, 1'b0);
        check_value("o_arready", arready, 1'b1);
        @(posedge clk);
        #(DRIVE_DELAY);

        foreach (steps[k]) begin
            run_step(steps[k]);
        end

        repeat (2) @(posedge clk);
        if (DUT.u_ctrl.u_assert.error_count != 0) begin
            abort_run("protocol assertions reported errors during the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: project.f
design/cache_pkg.sv
design/bus_pkg.sv
design/dp_ram.sv
design/cache.sv
design/line_mem.sv
design/cache_ctrl.sv
design/cache_top.sv
test/tb_clock.sv
test/cache_assertions.sv
test/cache_tb.sv

// File: Bender.yml
package:
  name: cache

sources:
  - design/cache_pkg.sv
  - design/bus_pkg.sv
  - design/dp_ram.sv
  - design/cache.sv
  - design/line_mem.sv
  - design/cache_ctrl.sv
  - design/cache_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/cache_assertions.sv
      - test/cache_tb.sv
